/* Makefile */
SIM      := verilator
FLAGS    := --binary --timing --assert -Wno-fatal -j 0
TOP      := core_tb
FILELIST := list.f
OBJDIR   := obj_dir
LOG      := sim.log
PASS_MSG := Simulation PASSED
FAIL_MSG := Simulation FAILED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "test failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "run ended early"; exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)

/* list.f */
+incdir+src
src/core_pkg.sv
src/core_fetch.sv
src/core_regfile.sv
src/core_decode.sv
src/core_execute.sv
src/core_writeback.sv
src/core_top.sv
tb/core_properties.sv
tb/core_tb.sv

/* src/core_decode.sv */
`default_nettype none
`timescale 1ns/10ps

`include "core_settings.svh"

module core_decode (
	input  logic                   clk,
	input  logic                   arst_n_i,
	input  logic                   fetch_valid_i,
	input  logic                   exe_ready_i,
	input  core_pkg::word_t        inst_i,
	input  core_pkg::word_t        pc_i,
	input  core_pkg::word_t        rs1_data_i,
	input  core_pkg::word_t        rs2_data_i,
	output logic                   dec_ready_o,
	output logic                   dec_valid_o,
	output core_pkg::reg_addr_t    rs1_addr_o,
	output core_pkg::reg_addr_t    rs2_addr_o,
	output core_pkg::reg_addr_t    rd_o,
	output core_pkg::word_t        pc_o,
	output core_pkg::word_t        rs1_val_o,
	output core_pkg::word_t        rs2_val_o,
	output core_pkg::word_t        imm_o,
	output core_pkg::alu_op_t      alu_op_o,
	output logic                   use_imm_o,
	output logic                   use_pc_o,
	output logic                   rd_we_o,
	output logic                   is_branch_o,
	output logic                   is_jump_o,
	output logic                   is_jalr_o,
	output logic                   illegal_o,
	output logic                   ebreak_o,
	output core_pkg::br_op_t       br_op_o
);

	logic [6:0]          opcode;
	logic [2:0]          funct3;
	logic [6:0]          funct7;
	core_pkg::reg_addr_t rd;
	core_pkg::word_t     imm_i_type;
	core_pkg::word_t     imm_b_type;
	core_pkg::word_t     imm_u_type;
	core_pkg::word_t     imm_j_type;
	core_pkg::word_t     imm;
	core_pkg::alu_op_t   alu_op;
	logic                legal;
	logic                use_imm;
	logic                use_pc;
	logic                is_branch;
	logic                is_jump;
	logic                is_jalr;
	logic                is_ebreak;
	logic                rd_we;
	logic                accept;

	// alt selects sub or sra
	function automatic core_pkg::alu_op_t alu_op_of(input logic [2:0] f3, input logic alt);
		case (f3)
			`F3_ADD_SUB: return alt ? `ALU_SUB : `ALU_ADD;
			`F3_SLL:     return `ALU_SLL;
			`F3_SLT:     return `ALU_SLT;
			`F3_SLTU:    return `ALU_SLTU;
			`F3_XOR:     return `ALU_XOR;
			`F3_SRL_SRA: return alt ? `ALU_SRA : `ALU_SRL;
			`F3_OR:      return `ALU_OR;
			default:     return `ALU_AND;
		endcase
	endfunction

	assign opcode     = inst_i[6:0];
	assign funct3     = inst_i[14:12];
	assign funct7     = inst_i[31:25];
	assign rd         = inst_i[11:7];
	assign rs1_addr_o = inst_i[19:15];
	assign rs2_addr_o = inst_i[24:20];

	assign imm_i_type = {{20{inst_i[31]}}, inst_i[31:20]};
	assign imm_b_type = {{20{inst_i[31]}}, inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
	assign imm_u_type = {inst_i[31:12], 12'b0};
	assign imm_j_type = {{12{inst_i[31]}}, inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

	assign is_ebreak = (inst_i == `INST_EBREAK);

	always_comb begin
		legal     = 1'b0;
		alu_op    = `ALU_ADD;
		use_imm   = 1'b0;
		use_pc    = 1'b0;
		is_branch = 1'b0;
		is_jump   = 1'b0;
		is_jalr   = 1'b0;
		imm       = imm_i_type;
		case (opcode)
			`OP_LUI: begin
				legal   = 1'b1;
				alu_op  = `ALU_PASSB;
				use_imm = 1'b1;
				imm     = imm_u_type;
			end
			`OP_AUIPC: begin
				legal   = 1'b1;
				use_imm = 1'b1;
				use_pc  = 1'b1;
				imm     = imm_u_type;
			end
			`OP_JAL: begin
				legal   = 1'b1;
				is_jump = 1'b1;
				imm     = imm_j_type;
			end
			`OP_JALR: begin
				legal   = (funct3 == `F3_JALR);
				is_jump = 1'b1;
				is_jalr = 1'b1;
			end
			`OP_BRANCH: begin
				legal     = funct3 inside {`F3_BEQ, `F3_BNE, `F3_BLT, `F3_BGE, `F3_BLTU, `F3_BGEU};
				is_branch = 1'b1;
				imm       = imm_b_type;
			end
			`OP_IMM: begin
				use_imm = 1'b1;
				alu_op  = alu_op_of(funct3, (funct3 == `F3_SRL_SRA) && funct7[5]);
				// shifts carry funct7 in the immediate
				case (funct3)
					`F3_SLL:     legal = (funct7 == `F7_BASE);
					`F3_SRL_SRA: legal = funct7 inside {`F7_BASE, `F7_ALT};
					default:     legal = 1'b1;
				endcase
			end
			`OP_REG: begin
				alu_op = alu_op_of(funct3, funct7[5]);
				legal  = (funct7 == `F7_BASE) ||
					((funct7 == `F7_ALT) && (funct3 inside {`F3_ADD_SUB, `F3_SRL_SRA}));
			end
			`OP_SYSTEM: begin
				legal = is_ebreak;
			end
			default: begin
				legal = 1'b0;
			end
		endcase
		// illegal words fall through to pc+4
		if (!legal) begin
			is_branch = 1'b0;
			is_jump   = 1'b0;
			is_jalr   = 1'b0;
		end
	end

	assign rd_we = legal && (rd != '0) && !is_branch && !is_ebreak;

	// holds a single item and is ready only while empty
	assign dec_ready_o = !dec_valid_o;
	assign accept      = fetch_valid_i && dec_ready_o;

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			dec_valid_o <= 1'b0;
		end else if (accept) begin
			dec_valid_o <= 1'b1;
		end else if (dec_valid_o && exe_ready_i) begin
			dec_valid_o <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			pc_o        <= pc_i;
			rs1_val_o   <= rs1_data_i;
			rs2_val_o   <= rs2_data_i;
			imm_o       <= imm;
			alu_op_o    <= alu_op;
			use_imm_o   <= use_imm;
			use_pc_o    <= use_pc;
			rd_o        <= rd;
			rd_we_o     <= rd_we;
			is_branch_o <= is_branch;
			br_op_o     <= funct3;
			is_jump_o   <= is_jump;
			is_jalr_o   <= is_jalr;
			illegal_o   <= !legal;
			ebreak_o    <= is_ebreak;
		end
	end

endmodule

`default_nettype wire

/* src/core_execute.sv */
`default_nettype none
`timescale 1ns/10ps

`include "core_settings.svh"

module core_execute (
	input  logic                   clk,
	input  logic                   arst_n_i,
	input  logic                   dec_valid_i,
	input  core_pkg::word_t        pc_i,
	input  core_pkg::word_t        rs1_val_i,
	input  core_pkg::word_t        rs2_val_i,
	input  core_pkg::word_t        imm_i,
	input  core_pkg::alu_op_t      alu_op_i,
	input  logic                   use_imm_i,
	input  logic                   use_pc_i,
	input  core_pkg::reg_addr_t    rd_i,
	input  logic                   rd_we_i,
	input  logic                   is_branch_i,
	input  core_pkg::br_op_t       br_op_i,
	input  logic                   is_jump_i,
	input  logic                   is_jalr_i,
	input  logic                   illegal_i,
	input  logic                   ebreak_i,
	input  logic                   wb_ready_i,
	output logic                   exe_ready_o,
	output logic                   exe_valid_o,
	output core_pkg::reg_addr_t    rd_o,
	output logic                   rd_we_o,
	output core_pkg::word_t        result_o,
	output core_pkg::word_t        next_pc_o,
	output logic                   illegal_o,
	output logic                   ebreak_o
);

	core_pkg::word_t op_a;
	core_pkg::word_t op_b;
	core_pkg::word_t alu_out;
	core_pkg::word_t pc_plus4;
	core_pkg::word_t next_pc;
	logic [4:0]      shamt;
	logic            taken;
	logic            accept;

	assign op_a     = use_pc_i ? pc_i : rs1_val_i;
	assign op_b     = use_imm_i ? imm_i : rs2_val_i;
	assign shamt    = op_b[4:0];
	assign pc_plus4 = pc_i + 32'd4;

	always_comb begin
		case (alu_op_i)
			`ALU_ADD:   alu_out = op_a + op_b;
			`ALU_SUB:   alu_out = op_a - op_b;
			`ALU_SLL:   alu_out = op_a << shamt;
			`ALU_SLT:   alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
			`ALU_SLTU:  alu_out = {31'b0, op_a < op_b};
			`ALU_XOR:   alu_out = op_a ^ op_b;
			`ALU_SRL:   alu_out = op_a >> shamt;
			`ALU_SRA:   alu_out = core_pkg::word_t'($signed(op_a) >>> shamt);
			`ALU_OR:    alu_out = op_a | op_b;
			`ALU_AND:   alu_out = op_a & op_b;
			`ALU_PASSB: alu_out = op_b;
			default:    alu_out = '0;
		endcase
	end

	// branch compare on the register operands
	always_comb begin
		case (br_op_i)
			`F3_BEQ:  taken = (rs1_val_i == rs2_val_i);
			`F3_BNE:  taken = (rs1_val_i != rs2_val_i);
			`F3_BLT:  taken = ($signed(rs1_val_i) < $signed(rs2_val_i));
			`F3_BGE:  taken = ($signed(rs1_val_i) >= $signed(rs2_val_i));
			`F3_BLTU: taken = (rs1_val_i < rs2_val_i);
			`F3_BGEU: taken = (rs1_val_i >= rs2_val_i);
			default:  taken = 1'b0;
		endcase
	end

	always_comb begin
		if (is_jalr_i) begin
			next_pc = (rs1_val_i + imm_i) & ~32'd1;
		end else if (is_jump_i || (is_branch_i && taken)) begin
			next_pc = pc_i + imm_i;
		end else begin
			next_pc = pc_plus4;
		end
	end

	assign exe_ready_o = !exe_valid_o;
	assign accept      = dec_valid_i && exe_ready_o;

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			exe_valid_o <= 1'b0;
		end else if (accept) begin
			exe_valid_o <= 1'b1;
		end else if (exe_valid_o && wb_ready_i) begin
			exe_valid_o <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			rd_o      <= rd_i;
			rd_we_o   <= rd_we_i;
			// jumps link pc+4
			result_o  <= is_jump_i ? pc_plus4 : alu_out;
			next_pc_o <= next_pc;
			illegal_o <= illegal_i;
			ebreak_o  <= ebreak_i;
		end
	end

endmodule

`default_nettype wire

/* src/core_fetch.sv */
`default_nettype none
`timescale 1ns/10ps

`include "core_settings.svh"

module core_fetch (
	input  logic                   clk,
	input  logic                   arst_n_i,
	input  logic                   finish_i,
	input  core_pkg::word_t        next_pc_i,
	input  logic                   dec_ready_i,
	output logic                   fetch_valid_o,
	output core_pkg::word_t        pc_o
);

	core_pkg::fetch_state_e state_q;

	// offer the pc until decode takes it, then wait for the last finish
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state_q <= core_pkg::FETCH_OFFER;
			pc_o    <= `CORE_RESET_PC;
		end else begin
			case (state_q)
				core_pkg::FETCH_OFFER: begin
					if (dec_ready_i) begin
						state_q <= core_pkg::FETCH_WAIT;
					end
				end
				core_pkg::FETCH_WAIT: begin
					// writeback hands back the next pc
					if (finish_i) begin
						pc_o    <= next_pc_i;
						state_q <= core_pkg::FETCH_OFFER;
					end
				end
				default: begin
					state_q <= core_pkg::FETCH_OFFER;
				end
			endcase
		end
	end

	assign fetch_valid_o = (state_q == core_pkg::FETCH_OFFER);

endmodule

`default_nettype wire

/* src/core_pkg.sv */
`default_nettype none

package core_pkg;

	// data word, instruction word or address
	typedef logic [31:0] word_t;

	// register index
	typedef logic [4:0] reg_addr_t;

	typedef logic [3:0] alu_op_t;

	// funct3 of a branch
	typedef logic [2:0] br_op_t;

	typedef enum logic {
		FETCH_OFFER,
		FETCH_WAIT
	} fetch_state_e;

endpackage

`default_nettype wire

/* src/core_regfile.sv */
`default_nettype none
`timescale 1ns/10ps

module core_regfile (
	input  logic                   clk,
	input  logic                   arst_n_i,
	input  core_pkg::reg_addr_t    raddr1_i,
	input  core_pkg::reg_addr_t    raddr2_i,
	input  core_pkg::reg_addr_t    waddr_i,
	input  logic                   we_i,
	input  core_pkg::word_t        wdata_i,
	output core_pkg::word_t        rdata1_o,
	output core_pkg::word_t        rdata2_o
);

	// x0 is not stored
	core_pkg::word_t regs [31:1];

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			for (int i = 1; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (we_i && (waddr_i != '0)) begin
			regs[waddr_i] <= wdata_i;
		end
	end

	assign rdata1_o = (raddr1_i == '0) ? '0 : regs[raddr1_i];
	assign rdata2_o = (raddr2_i == '0) ? '0 : regs[raddr2_i];

endmodule

`default_nettype wire

/* src/core_settings.svh */
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// first fetch address after reset
`define CORE_RESET_PC 32'h8000_0000

// rv32i major opcodes
`define OP_LUI    7'b0110111
`define OP_AUIPC  7'b0010111
`define OP_JAL    7'b1101111
`define OP_JALR   7'b1100111
`define OP_BRANCH 7'b1100011
`define OP_IMM    7'b0010011
`define OP_REG    7'b0110011
`define OP_SYSTEM 7'b1110011

`define INST_EBREAK 32'h0010_0073

// funct3 of the alu groups
`define F3_ADD_SUB 3'b000
`define F3_SLL     3'b001
`define F3_SLT     3'b010
`define F3_SLTU    3'b011
`define F3_XOR     3'b100
`define F3_SRL_SRA 3'b101
`define F3_OR      3'b110
`define F3_AND     3'b111
`define F3_JALR    3'b000

// funct3 of the branches
`define F3_BEQ  3'b000
`define F3_BNE  3'b001
`define F3_BLT  3'b100
`define F3_BGE  3'b101
`define F3_BLTU 3'b110
`define F3_BGEU 3'b111

// base funct7 and the alternate one for sub and sra
`define F7_BASE 7'b0000000
`define F7_ALT  7'b0100000

// alu operation codes
`define ALU_ADD   4'd0
`define ALU_SUB   4'd1
`define ALU_SLL   4'd2
`define ALU_SLT   4'd3
`define ALU_SLTU  4'd4
`define ALU_XOR   4'd5
`define ALU_SRL   4'd6
`define ALU_SRA   4'd7
`define ALU_OR    4'd8
`define ALU_AND   4'd9
`define ALU_PASSB 4'd10

`endif

/* src/core_top.sv */
`default_nettype none
`timescale 1ns/10ps

module core_top (
	input  logic                   clk,
	input  logic                   arst_n_i,
	input  core_pkg::word_t        inst_i,
	output core_pkg::word_t        pc_o,
	output logic                   retire_o,
	output logic                   invalid_o,
	output logic                   halt_o,
	output logic                   rd_we_o,
	output core_pkg::reg_addr_t    rd_addr_o,
	output core_pkg::word_t        rd_data_o
);

	// fetch and register file
	logic                fetch_valid;
	logic                dec_ready;
	logic                last_finish;
	core_pkg::word_t     wb_next_pc;
	core_pkg::reg_addr_t rs1_addr;
	core_pkg::reg_addr_t rs2_addr;
	core_pkg::word_t     rs1_data;
	core_pkg::word_t     rs2_data;

	// decode to execute
	logic                dec_valid;
	logic                exe_ready;
	core_pkg::word_t     dec_pc;
	core_pkg::word_t     dec_rs1_val;
	core_pkg::word_t     dec_rs2_val;
	core_pkg::word_t     dec_imm;
	core_pkg::alu_op_t   dec_alu_op;
	logic                dec_use_imm;
	logic                dec_use_pc;
	core_pkg::reg_addr_t dec_rd;
	logic                dec_rd_we;
	logic                dec_is_branch;
	core_pkg::br_op_t    dec_br_op;
	logic                dec_is_jump;
	logic                dec_is_jalr;
	logic                dec_illegal;
	logic                dec_ebreak;

	// execute to writeback
	logic                exe_valid;
	logic                wb_ready;
	core_pkg::reg_addr_t exe_rd;
	logic                exe_rd_we;
	core_pkg::word_t     exe_result;
	core_pkg::word_t     exe_next_pc;
	logic                exe_illegal;
	logic                exe_ebreak;

	core_fetch u_fetch (
		.clk           (clk),
		.arst_n_i      (arst_n_i),
		.finish_i      (last_finish),
		.next_pc_i     (wb_next_pc),
		.dec_ready_i   (dec_ready),
		.fetch_valid_o (fetch_valid),
		.pc_o          (pc_o)
	);

	core_regfile u_regfile (
		.clk      (clk),
		.arst_n_i (arst_n_i),
		.raddr1_i (rs1_addr),
		.raddr2_i (rs2_addr),
		.waddr_i  (rd_addr_o),
		.we_i     (rd_we_o),
		.wdata_i  (rd_data_o),
		.rdata1_o (rs1_data),
		.rdata2_o (rs2_data)
	);

	core_decode u_decode (
		.clk           (clk),
		.arst_n_i      (arst_n_i),
		.fetch_valid_i (fetch_valid),
		.exe_ready_i   (exe_ready),
		.inst_i        (inst_i),
		.pc_i          (pc_o),
		.rs1_data_i    (rs1_data),
		.rs2_data_i    (rs2_data),
		.dec_ready_o   (dec_ready),
		.dec_valid_o   (dec_valid),
		.rs1_addr_o    (rs1_addr),
		.rs2_addr_o    (rs2_addr),
		.rd_o          (dec_rd),
		.pc_o          (dec_pc),
		.rs1_val_o     (dec_rs1_val),
		.rs2_val_o     (dec_rs2_val),
		.imm_o         (dec_imm),
		.alu_op_o      (dec_alu_op),
		.use_imm_o     (dec_use_imm),
		.use_pc_o      (dec_use_pc),
		.rd_we_o       (dec_rd_we),
		.is_branch_o   (dec_is_branch),
		.is_jump_o     (dec_is_jump),
		.is_jalr_o     (dec_is_jalr),
		.illegal_o     (dec_illegal),
		.ebreak_o      (dec_ebreak),
		.br_op_o       (dec_br_op)
	);

	core_execute u_execute (
		.clk         (clk),
		.arst_n_i    (arst_n_i),
		.dec_valid_i (dec_valid),
		.pc_i        (dec_pc),
		.rs1_val_i   (dec_rs1_val),
		.rs2_val_i   (dec_rs2_val),
		.imm_i       (dec_imm),
		.alu_op_i    (dec_alu_op),
		.use_imm_i   (dec_use_imm),
		.use_pc_i    (dec_use_pc),
		.rd_i        (dec_rd),
		.rd_we_i     (dec_rd_we),
		.is_branch_i (dec_is_branch),
		.br_op_i     (dec_br_op),
		.is_jump_i   (dec_is_jump),
		.is_jalr_i   (dec_is_jalr),
		.illegal_i   (dec_illegal),
		.ebreak_i    (dec_ebreak),
		.wb_ready_i  (wb_ready),
		.exe_ready_o (exe_ready),
		.exe_valid_o (exe_valid),
		.rd_o        (exe_rd),
		.rd_we_o     (exe_rd_we),
		.result_o    (exe_result),
		.next_pc_o   (exe_next_pc),
		.illegal_o   (exe_illegal),
		.ebreak_o    (exe_ebreak)
	);

	// writeback drives the register file port that the top exposes
	core_writeback u_writeback (
		.clk         (clk),
		.arst_n_i    (arst_n_i),
		.exe_valid_i (exe_valid),
		.rd_i        (exe_rd),
		.rd_we_i     (exe_rd_we),
		.result_i    (exe_result),
		.next_pc_i   (exe_next_pc),
		.illegal_i   (exe_illegal),
		.ebreak_i    (exe_ebreak),
		.wb_ready_o  (wb_ready),
		.rf_we_o     (rd_we_o),
		.rf_waddr_o  (rd_addr_o),
		.rf_wdata_o  (rd_data_o),
		.retire_o    (retire_o),
		.invalid_o   (invalid_o),
		.halt_o      (halt_o),
		.finish_o    (last_finish),
		.next_pc_o   (wb_next_pc)
	);

endmodule

`default_nettype wire

/* src/core_writeback.sv */
`default_nettype none
`timescale 1ns/10ps

module core_writeback (
	input  logic                   clk,
	input  logic                   arst_n_i,
	input  logic                   exe_valid_i,
	input  core_pkg::reg_addr_t    rd_i,
	input  logic                   rd_we_i,
	input  core_pkg::word_t        result_i,
	input  core_pkg::word_t        next_pc_i,
	input  logic                   illegal_i,
	input  logic                   ebreak_i,
	output logic                   wb_ready_o,
	output logic                   rf_we_o,
	output core_pkg::reg_addr_t    rf_waddr_o,
	output core_pkg::word_t        rf_wdata_o,
	output logic                   retire_o,
	output logic                   invalid_o,
	output logic                   halt_o,
	output logic                   finish_o,
	output core_pkg::word_t        next_pc_o
);

	logic                wb_valid;
	logic                rd_we_q;
	logic                illegal_q;
	logic                ebreak_q;
	logic                halt_q;
	core_pkg::reg_addr_t rd_q;
	core_pkg::word_t     result_q;
	core_pkg::word_t     next_pc_q;

	assign wb_ready_o = !wb_valid;

	// item stays for one cycle only
	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			wb_valid <= 1'b0;
			halt_q   <= 1'b0;
		end else begin
			wb_valid <= exe_valid_i && wb_ready_o;
			halt_q   <= halt_q || (wb_valid && ebreak_q);
		end
	end

	always_ff @(posedge clk) begin
		if (exe_valid_i && wb_ready_o) begin
			rd_q      <= rd_i;
			rd_we_q   <= rd_we_i;
			result_q  <= result_i;
			next_pc_q <= next_pc_i;
			illegal_q <= illegal_i;
			ebreak_q  <= ebreak_i;
		end
	end

	assign retire_o   = wb_valid;
	assign rf_we_o    = wb_valid && rd_we_q;
	assign rf_waddr_o = rd_q;
	assign rf_wdata_o = result_q;
	assign invalid_o  = wb_valid && illegal_q;
	// ebreak keeps fetch parked
	assign finish_o   = wb_valid && !ebreak_q;
	assign next_pc_o  = next_pc_q;
	assign halt_o     = halt_q || (wb_valid && ebreak_q);

endmodule

`default_nettype wire

/* tb/core_properties.sv */
`default_nettype none
`timescale 1ns/10ps

module core_properties (
	input  logic                   clk,
	input  logic                   arst_n_i,
	input  core_pkg::word_t        pc_i,
	input  logic                   retire_i,
	input  logic                   invalid_i,
	input  logic                   halt_i,
	input  logic                   rd_we_i,
	input  core_pkg::reg_addr_t    rd_addr_i
);

	// failed properties so far
	int violations = 0;

	// halt is sticky
	halt_sticky: assert property (@(posedge clk) disable iff (!arst_n_i) halt_i |=> halt_i)
		else begin
			violations++;
			$error("halt_o dropped after it was raised");
		end

	// retire is a single cycle pulse
	retire_pulse: assert property (@(posedge clk) disable iff (!arst_n_i) retire_i |=> !retire_i)
		else begin
			violations++;
			$error("retire_o high for more than one cycle");
		end

	no_retire_after_halt: assert property (@(posedge clk) disable iff (!arst_n_i)
		halt_i |=> !retire_i)
		else begin
			violations++;
			$error("retire_o after halt_o");
		end

	no_x0_write: assert property (@(posedge clk) disable iff (!arst_n_i)
		rd_we_i |-> (rd_addr_i != 5'd0))
		else begin
			violations++;
			$error("rd_we_o high with rd_addr_o zero");
		end

	invalid_no_write: assert property (@(posedge clk) disable iff (!arst_n_i)
		invalid_i |-> (retire_i && !rd_we_i))
		else begin
			violations++;
			$error("invalid_o without a retire, or with a register write");
		end

	// pc moves only at retirement
	pc_stable: assert property (@(posedge clk) disable iff (!arst_n_i)
		!retire_i |=> $stable(pc_i))
		else begin
			violations++;
			$error("pc_o changed without a retirement");
		end

endmodule

`default_nettype wire

/* tb/core_tb.sv */
`default_nettype none
`timescale 1ns/10ps

`include "core_settings.svh"

module core_tb;

	localparam int PROG_LEN  = 202;
	localparam int RUN_LIMIT = 4000;

	logic                clk;
	logic                arst_n_i;
	core_pkg::word_t     inst_i;
	core_pkg::word_t     pc_o;
	logic                retire_o;
	logic                invalid_o;
	logic                halt_o;
	logic                rd_we_o;
	core_pkg::reg_addr_t rd_addr_o;
	core_pkg::word_t     rd_data_o;

	core_pkg::word_t     imem [0:255];
	core_pkg::word_t     pc_offset;

	// architectural state of the reference model
	core_pkg::word_t     xreg [0:31];
	core_pkg::word_t     mpc;

	// expected effect of the retiring instruction
	logic                exp_we;
	logic                exp_invalid;
	logic                exp_halt;
	core_pkg::reg_addr_t exp_rd;
	core_pkg::word_t     exp_data;
	core_pkg::word_t     exp_next;

	integer              seed;
	int                  value_errors;
	int                  other_errors;
	int                  retired;
	int                  since_retire;
	int                  cycles;
	logic                done;
	logic                pc_due;

	core_top dut (
		.clk       (clk),
		.arst_n_i  (arst_n_i),
		.inst_i    (inst_i),
		.pc_o      (pc_o),
		.retire_o  (retire_o),
		.invalid_o (invalid_o),
		.halt_o    (halt_o),
		.rd_we_o   (rd_we_o),
		.rd_addr_o (rd_addr_o),
		.rd_data_o (rd_data_o)
	);

	bind core_top core_properties u_properties (
		.clk       (clk),
		.arst_n_i  (arst_n_i),
		.pc_i      (pc_o),
		.retire_i  (retire_o),
		.invalid_i (invalid_o),
		.halt_i    (halt_o),
		.rd_we_i   (rd_we_o),
		.rd_addr_i (rd_addr_o)
	);

	// anything outside the program reads as ebreak
	assign pc_offset = pc_o - `CORE_RESET_PC;
	assign inst_i    = (pc_offset[1:0] == 2'b00 && pc_offset < 32'(4 * PROG_LEN)) ?
		imem[pc_offset[9:2]] : `INST_EBREAK;

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	function automatic core_pkg::word_t word_at(input core_pkg::word_t addr);
		core_pkg::word_t off;
		off = addr - `CORE_RESET_PC;
		if (off[1:0] == 2'b00 && off < 32'(4 * PROG_LEN)) begin
			return imem[off[9:2]];
		end
		return `INST_EBREAK;
	endfunction

	function automatic core_pkg::word_t alu_ref(input logic [2:0] f3, input logic alt,
		input core_pkg::word_t a, input core_pkg::word_t b);
		case (f3)
			3'd0:    return alt ? a - b : a + b;
			3'd1:    return a << b[4:0];
			3'd2:    return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			3'd3:    return (a < b) ? 32'd1 : 32'd0;
			3'd4:    return a ^ b;
			3'd5:    return alt ? core_pkg::word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'd6:    return a | b;
			default: return a & b;
		endcase
	endfunction

	task automatic report_mismatch(input string name, input core_pkg::word_t expected,
		input core_pkg::word_t actual);
		value_errors++;
		$display("ERROR t=%0t %s expected %h actual %h", $time, name, expected, actual);
	endtask

	// forward control flow only so the run always reaches the final ebreak
	task automatic build_program();
		int                  kind;
		int                  hop;
		logic [31:0]         r;
		logic [20:0]         off;
		logic [11:0]         imm12;
		logic [6:0]          f7;
		logic [2:0]          f3;
		core_pkg::reg_addr_t rd;
		core_pkg::reg_addr_t rs1;
		core_pkg::reg_addr_t rs2;
		imem[0] = {20'h0, 5'd31, `OP_AUIPC};
		for (int i = 1; i < PROG_LEN - 1; i++) begin
			r    = $random(seed);
			kind = $unsigned($random(seed)) % 20;
			hop  = 1 + ($unsigned($random(seed)) % 4);
			rd   = 5'($unsigned($random(seed)) % 31);
			rs1  = r[19:15];
			rs2  = r[24:20];
			f3   = r[14:12];
			if (i + hop > PROG_LEN - 1) begin
				hop = PROG_LEN - 1 - i;
			end
			off = 21'(hop * 4);
			if (kind <= 5 || kind == 18) begin
				f7 = (r[30] && (f3 == 3'd0 || f3 == 3'd5)) ? `F7_ALT : `F7_BASE;
				imem[i] = {f7, rs2, rs1, f3, rd, `OP_REG};
			end else if (kind <= 10) begin
				imm12 = r[31:20];
				if (f3 == 3'd1) begin
					imm12 = {7'd0, r[24:20]};
				end
				if (f3 == 3'd5) begin
					imm12 = {r[30] ? `F7_ALT : `F7_BASE, r[24:20]};
				end
				imem[i] = {imm12, rs1, f3, rd, `OP_IMM};
			end else if (kind == 11) begin
				imem[i] = {r[31:12], rd, `OP_LUI};
			end else if (kind == 12) begin
				imem[i] = {r[31:12], rd, `OP_AUIPC};
			end else if (kind <= 15) begin
				// map the two reserved codes onto blt and bge
				if (f3 == 3'd2 || f3 == 3'd3) begin
					f3 = f3 ^ 3'b110;
				end
				imem[i] = {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `OP_BRANCH};
			end else if (kind == 16) begin
				imem[i] = {off[20], off[10:1], off[11], off[19:12], rd, `OP_JAL};
			end else if (kind == 17) begin
				imem[i] = {12'((i + hop) * 4), 5'd31, `F3_JALR, rd, `OP_JALR};
			end else if (r[0]) begin
				// unsupported load
				imem[i] = {r[31:7], 7'b0000011};
			end else begin
				// multiply extension funct7
				imem[i] = {7'b0000001, rs2, rs1, f3, rd, `OP_REG};
			end
		end
		imem[PROG_LEN - 1] = `INST_EBREAK;
	endtask

	task automatic model_step(input core_pkg::word_t inst);
		logic [6:0]      op;
		logic [2:0]      f3;
		logic [6:0]      f7;
		core_pkg::word_t a;
		core_pkg::word_t b;
		core_pkg::word_t imm;
		logic            ok;
		logic            wr;
		logic            take;
		op   = inst[6:0];
		f3   = inst[14:12];
		f7   = inst[31:25];
		a    = xreg[inst[19:15]];
		b    = xreg[inst[24:20]];
		imm  = {{20{inst[31]}}, inst[31:20]};
		ok   = 1'b1;
		wr   = 1'b1;
		take = 1'b0;
		exp_data = '0;
		exp_next = mpc + 32'd4;
		exp_halt = 1'b0;
		case (op)
			`OP_LUI:   exp_data = {inst[31:12], 12'b0};
			`OP_AUIPC: exp_data = mpc + {inst[31:12], 12'b0};
			`OP_JAL: begin
				exp_data = mpc + 32'd4;
				exp_next = mpc + {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
			end
			`OP_JALR: begin
				ok       = (f3 == 3'd0);
				exp_data = mpc + 32'd4;
				exp_next = (a + imm) & ~32'd1;
			end
			`OP_BRANCH: begin
				wr = 1'b0;
				case (f3)
					3'd0:    take = (a == b);
					3'd1:    take = (a != b);
					3'd4:    take = ($signed(a) < $signed(b));
					3'd5:    take = ($signed(a) >= $signed(b));
					3'd6:    take = (a < b);
					3'd7:    take = (a >= b);
					default: ok = 1'b0;
				endcase
				if (take) begin
					exp_next = mpc + {{20{inst[31]}}, inst[7], inst[30:25], inst[11:8], 1'b0};
				end
			end
			`OP_IMM: begin
				if (f3 == 3'd1) begin
					ok = (f7 == 7'h00);
				end
				if (f3 == 3'd5) begin
					ok = (f7 == 7'h00) || (f7 == 7'h20);
				end
				exp_data = alu_ref(f3, (f3 == 3'd5) && f7[5], a, imm);
			end
			`OP_REG: begin
				ok = (f7 == 7'h00) || ((f7 == 7'h20) && (f3 == 3'd0 || f3 == 3'd5));
				exp_data = alu_ref(f3, f7[5], a, b);
			end
			`OP_SYSTEM: begin
				ok       = (inst == `INST_EBREAK);
				exp_halt = ok;
				wr       = 1'b0;
			end
			default: ok = 1'b0;
		endcase
		if (!ok) begin
			exp_next = mpc + 32'd4;
		end
		exp_invalid = !ok;
		exp_rd      = inst[11:7];
		exp_we      = ok && wr && (exp_rd != 5'd0);
	endtask

	task automatic check_idle();
		assert (pc_o == `CORE_RESET_PC) else report_mismatch("pc_o", `CORE_RESET_PC, pc_o);
		assert (!retire_o) else report_mismatch("retire_o", 32'd0, 32'(retire_o));
		assert (!rd_we_o) else report_mismatch("rd_we_o", 32'd0, 32'(rd_we_o));
		assert (!halt_o) else report_mismatch("halt_o", 32'd0, 32'(halt_o));
	endtask

	task automatic check_retire();
		model_step(word_at(mpc));
		assert (pc_o == mpc) else report_mismatch("pc_o", mpc, pc_o);
		assert (retired == 0 || since_retire == 4) else begin
			other_errors++;
			$display("retirement came %0d cycles after the previous one", since_retire);
		end
		assert (invalid_o == exp_invalid)
			else report_mismatch("invalid_o", 32'(exp_invalid), 32'(invalid_o));
		assert (rd_we_o == exp_we) else report_mismatch("rd_we_o", 32'(exp_we), 32'(rd_we_o));
		assert (halt_o == exp_halt) else report_mismatch("halt_o", 32'(exp_halt), 32'(halt_o));
		if (exp_we) begin
			assert (rd_addr_o == exp_rd)
				else report_mismatch("rd_addr_o", 32'(exp_rd), 32'(rd_addr_o));
			assert (rd_data_o == exp_data) else report_mismatch("rd_data_o", exp_data, rd_data_o);
			xreg[exp_rd] = exp_data;
		end
		// the model stays on the ebreak address
		if (!exp_halt) begin
			mpc = exp_next;
		end
		retired++;
		since_retire = 0;
		done   = exp_halt;
		pc_due = !exp_halt;
	endtask

	initial begin
		arst_n_i     = 1'b0;
		seed         = 39194;
		value_errors = 0;
		other_errors = 0;
		retired      = 0;
		since_retire = 0;
		done         = 1'b0;
		pc_due       = 1'b0;
		build_program();
		for (int i = 0; i < 32; i++) begin
			xreg[i] = '0;
		end
		mpc = `CORE_RESET_PC;
		repeat (10) begin
			@(negedge clk);
			check_idle();
		end
		arst_n_i = 1'b1;
		@(negedge clk);
		check_idle();
		cycles = 1;
		since_retire = 1;
		while (!done && cycles < RUN_LIMIT) begin
			@(negedge clk);
			cycles++;
			since_retire++;
			if (pc_due) begin
				assert (pc_o == mpc) else report_mismatch("pc_o", mpc, pc_o);
				pc_due = 1'b0;
			end
			assert (!(rd_we_o && rd_addr_o == 5'd0)) else begin
				other_errors++;
				$display("register write to x0 at t=%0t", $time);
			end
			if (retire_o) begin
				check_retire();
			end else begin
				assert (!halt_o) else report_mismatch("halt_o", 32'd0, 32'(halt_o));
			end
		end
		if (!done) begin
			other_errors++;
			$display("halt did not arrive within %0d cycles", RUN_LIMIT);
		end else begin
			// core parked on the ebreak
			repeat (20) begin
				@(negedge clk);
				assert (halt_o) else report_mismatch("halt_o", 32'd1, 32'(halt_o));
				assert (!retire_o) else report_mismatch("retire_o", 32'd0, 32'(retire_o));
				assert (pc_o == mpc) else report_mismatch("pc_o", mpc, pc_o);
			end
		end
		$display("retired %0d, value errors %0d, other errors %0d, property failures %0d",
			retired, value_errors, other_errors, dut.u_properties.violations);
		if (value_errors + other_errors + dut.u_properties.violations == 0) begin
			$display("Simulation PASSED");
		end else begin
			$display("Simulation FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
